// ==== compile.f ====
+incdir+sim
source/scope_cfg_pkg.sv
source/scope_bus_pkg.sv
source/sample_decimator.sv
source/edge_trigger.sv
source/capture_ram.sv
source/scope_wb_regs.sv
source/scope_capture_top.sv
sim/scope_capture_tb.sv

// ==== sim/scope_tb_wb.svh ====
`ifndef SCOPE_TB_WB_SVH
`define SCOPE_TB_WB_SVH

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic master
    //////////////////////////////////////////////////////////////////////

    // One read or write, drop the strobe in the ack cycle
    task automatic wb_transfer(input logic we, input int adr, input int wdata,
                               output int rdata);
        int waited;
        waited = 0;
        rdata  = 0;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = scope_bus_pkg::wb_adr_t'(adr);
        wb_req.dat = scope_bus_pkg::wb_dat_t'(wdata);
        @(negedge clk);
        // Ack should come one clock after the request
        while (!wb_rsp.ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_rsp.ack) begin
            rdata = int'(wb_rsp.dat);
            if (waited != 0) report_mismatch("wb_rsp.ack latency", waited + 1, 1);
        end else begin
            $display("Bus failure at %0t ns: no ack for address 0x%0h", $time, adr);
            error_count++;
        end
        wb_req = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model of decimation, trigger and record
    //////////////////////////////////////////////////////////////////////

    // Replays every valid sample of the run, group phase kept across runs
    task automatic predict_record(input int level, input int hyst, input int decim,
                                  output int entries);
        int low_thr;
        int phase;
        int s;
        low_thr = (level > hyst) ? level - hyst : 0;
        // 0 wait low, 1 wait high, 2 capture, 3 done
        phase   = 0;
        entries = 0;
        foreach (valid_q[i]) begin
            if (model_grp_cnt >= decim) begin
                model_grp_cnt = 0;
                s = int'(valid_q[i]);
                case (phase)
                    0: if (s <= low_thr) phase = 1;
                    1: begin
                        if (s >= level) begin
                            exp_rec[0] = s;
                            entries    = 1;
                            phase      = 2;
                        end
                    end
                    2: begin
                        exp_rec[entries] = s;
                        entries++;
                        if (entries == DEPTH) phase = 3;
                    end
                    // Record frozen, later samples ignored
                    default: phase = 3;
                endcase
            end else begin
                model_grp_cnt++;
            end
        end
    endtask

`endif

// ==== sim/scope_capture_tb.sv ====
`timescale 1ns/1ps

module scope_capture_tb;

    localparam int DEPTH           = 256;
    localparam int NUM_ROWS        = 5;
    localparam int MAX_DECIM       = 7;
    localparam int MAX_WAVE_PERIOD = 160;
    localparam int MAX_HOLD        = 1600;
    localparam int ACK_WAIT        = 16;
    // Per row, record at worst decimation with gaps, hold, trigger search, readout
    localparam int TIMEOUT_CYCLES  =
        NUM_ROWS * (DEPTH * (MAX_DECIM + 1) * 2 + MAX_WAVE_PERIOD * 4 + MAX_HOLD + 2000) * 4;

    typedef struct packed {
        int level;
        int hyst;
        int decim;
        int step;
        int gap_pct;
        int wave_lo;
        int wave_hi;
        int hold_lo;
        int hold_cycles;
    } stim_row_t;

    // level, hyst, decim, step, gap %, wave lo, wave hi, hold lo, hold cycles
    stim_row_t test_table [NUM_ROWS] = '{
        '{2048, 256,  0, 37,  0, 1000, 3000,    0,    0},
        '{1500, 100,  3, 23, 30,  800, 2600,    0,    0},
        '{2500, 600,  1, 41, 50,  500, 3500, 2000, 1600},
        '{3000, 3500, 0, 63,  0,    0, 4000,    0,    0},
        '{1024, 64,   7, 29, 10,  200, 2200,    0,    0}
    };

    logic                   clk;
    logic                   rst;
    scope_cfg_pkg::sample_t sample_in;
    logic                   sample_valid;
    scope_bus_pkg::wb_req_t wb_req;
    scope_bus_pkg::wb_rsp_t wb_rsp;

    // Every sample sent with valid high, in order
    scope_cfg_pkg::sample_t valid_q [$];

    int  exp_rec [DEPTH];
    int  got_rec [DEPTH];
    int  model_grp_cnt;
    int  error_count;
    int  failed_tests;
    int  cycle_count;
    bit  stream_on;
    bit  stream_busy;

    scope_capture_top #(
        .CAPTURE_DEPTH (DEPTH)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp)
    );

    `include "scope_tb_wb.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, capture never completed", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // Log an unexpected value
    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        error_count++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Triangle wave ADC source
    //////////////////////////////////////////////////////////////////////

    task automatic stream_wave(input stim_row_t row);
        int  v;
        int  dir;
        int  lo;
        int  cyc;
        bit  running;
        lo      = (row.hold_cycles > 0) ? row.hold_lo : row.wave_lo;
        v       = lo;
        dir     = 1;
        cyc     = 0;
        running = 1'b1;
        while (running) begin
            @(negedge clk);
            if (!stream_on) begin
                sample_valid = 1'b0;
                running      = 1'b0;
            end else begin
                // Hold phase over, wave may now dip below the rearm point
                if (cyc == row.hold_cycles) lo = row.wave_lo;
                sample_in    = scope_cfg_pkg::sample_t'(v);
                sample_valid = ($urandom % 100) >= row.gap_pct;
                if (sample_valid) valid_q.push_back(sample_in);
                v = v + dir * row.step;
                if (v >= row.wave_hi) begin
                    v   = row.wave_hi;
                    dir = -1;
                end else if (v <= lo) begin
                    v   = lo;
                    dir = 1;
                end
                cyc++;
            end
        end
        stream_busy = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int        rdata;
        int        entries;
        int        test_err;
        stim_row_t row;
        int        reg_adr [3];
        int        reg_val [3];

        void'($urandom(22));
        rst           = 1'b1;
        sample_in     = '0;
        sample_valid  = 1'b0;
        wb_req        = '0;
        stream_on     = 1'b0;
        stream_busy   = 1'b0;
        model_grp_cnt = 0;
        error_count   = 0;
        failed_tests  = 0;
        cycle_count   = 0;
        reg_adr       = '{scope_bus_pkg::REG_LEVEL, scope_bus_pkg::REG_HYST,
                          scope_bus_pkg::REG_DECIM};
        reg_val       = '{12'hA5C, 12'h3C1, 12'h00F};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values, readback, read-only and unmapped addresses
        test_err = error_count;
        wb_transfer(1'b0, scope_bus_pkg::REG_STATUS, 0, rdata);
        if (rdata != 0) report_mismatch("wb_rsp.dat REG_STATUS", rdata, 0);
        for (int i = 0; i < 3; i++) begin
            wb_transfer(1'b0, reg_adr[i], 0, rdata);
            if (rdata != 0) report_mismatch("wb_rsp.dat reset config", rdata, 0);
            wb_transfer(1'b1, reg_adr[i], reg_val[i], rdata);
            wb_transfer(1'b0, reg_adr[i], 0, rdata);
            if (rdata != reg_val[i]) report_mismatch("wb_rsp.dat readback", rdata, reg_val[i]);
        end
        // Unmapped read right after a nonzero readback
        wb_transfer(1'b0, 10'h005, 0, rdata);
        if (rdata != 0) report_mismatch("wb_rsp.dat unmapped", rdata, 0);
        // Status is read only, a write there must not arm
        wb_transfer(1'b1, scope_bus_pkg::REG_STATUS, 16'h0003, rdata);
        wb_transfer(1'b0, scope_bus_pkg::REG_STATUS, 0, rdata);
        if (rdata != 0) report_mismatch("wb_rsp.dat REG_STATUS after write", rdata, 0);
        if (error_count != test_err) failed_tests++;
        $display("Test 0 registers: %0d errors", error_count - test_err);

        for (int t = 0; t < NUM_ROWS; t++) begin
            row      = test_table[t];
            test_err = error_count;
            wb_transfer(1'b1, scope_bus_pkg::REG_LEVEL, row.level, rdata);
            wb_transfer(1'b1, scope_bus_pkg::REG_HYST, row.hyst, rdata);
            wb_transfer(1'b1, scope_bus_pkg::REG_DECIM, row.decim, rdata);
            // Arm, done from the previous record must clear
            wb_transfer(1'b1, scope_bus_pkg::REG_CTRL, 1, rdata);
            wb_transfer(1'b0, scope_bus_pkg::REG_STATUS, 0, rdata);
            if (rdata != 1) report_mismatch("wb_rsp.dat status after arm", rdata, 1);

            valid_q.delete();
            stream_on   = 1'b1;
            stream_busy = 1'b1;
            fork
                stream_wave(row);
            join_none

            // Level crossings without a dip must leave it armed
            // A capture started by such a crossing would be done by now
            if (row.hold_cycles > 0) begin
                repeat (row.hold_cycles - 60) @(negedge clk);
                wb_transfer(1'b0, scope_bus_pkg::REG_STATUS, 0, rdata);
                if (rdata != 1) report_mismatch("wb_rsp.dat status in hold", rdata, 1);
            end

            rdata = 0;
            while (rdata[1] == 1'b0) begin
                wb_transfer(1'b0, scope_bus_pkg::REG_STATUS, 0, rdata);
            end

            // Read out with samples still arriving
            repeat (100) @(negedge clk);
            for (int i = 0; i < DEPTH; i++) begin
                wb_transfer(1'b0, int'(scope_bus_pkg::BUF_BASE) + i, 0, rdata);
                got_rec[i] = rdata;
            end
            @(posedge clk);
            stream_on = 1'b0;
            wait (!stream_busy);
            wb_transfer(1'b0, scope_bus_pkg::REG_STATUS, 0, rdata);
            if (rdata != 2) report_mismatch("wb_rsp.dat status when done", rdata, 2);

            predict_record(row.level, row.hyst, row.decim, entries);
            if (entries != DEPTH) begin
                $display("Test %0d: model predicts only %0d of %0d entries, stimulus too short",
                         t + 1, entries, DEPTH);
                error_count++;
            end else begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (got_rec[i] != exp_rec[i]) begin
                        report_mismatch($sformatf("wb_rsp.dat buffer[%0d]", i),
                                        got_rec[i], exp_rec[i]);
                    end
                end
            end
            if (error_count != test_err) failed_tests++;
            $display("Test %0d capture, level %0d hyst %0d decim %0d: %0d errors",
                     t + 1, row.level, row.hyst, row.decim, error_count - test_err);
        end

        $display("Tests run %0d, failed %0d, errors %0d, cycles %0d",
                 NUM_ROWS + 1, failed_tests, error_count, cycle_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== source/capture_ram.sv ====
`timescale 1ns/1ps

module capture_ram #(
    parameter int CAPTURE_DEPTH = scope_cfg_pkg::DEFAULT_DEPTH
) (
    input  logic                             clk,
    input  scope_cfg_pkg::cap_wr_t           cap_wr,
    input  logic [$clog2(CAPTURE_DEPTH)-1:0] rd_addr,
    output scope_cfg_pkg::sample_t           rd_data
);

    localparam int AW = $clog2(CAPTURE_DEPTH);

    // Record storage, one ADC code per entry
    scope_cfg_pkg::sample_t mem [CAPTURE_DEPTH];

    // Only the bits inside the depth select a word
    logic [AW-1:0] wr_addr;

    assign wr_addr = cap_wr.addr[AW-1:0];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cap_wr.en) begin
            mem[wr_addr] <= cap_wr.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port, one clock from address to data
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== source/edge_trigger.sv ====
`timescale 1ns/1ps

module edge_trigger #(
    parameter int CAPTURE_DEPTH = scope_cfg_pkg::DEFAULT_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  scope_cfg_pkg::trig_cfg_t  cfg,
    input  logic                      arm,
    input  scope_cfg_pkg::sample_t    dec_sample,
    input  logic                      dec_valid,
    output scope_cfg_pkg::cap_wr_t    cap_wr,
    output logic                      armed,
    output logic                      done
);

    localparam int AW = $clog2(CAPTURE_DEPTH);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_LOW,
        WAIT_HIGH,
        CAPTURE,
        DONE
    } trig_state_t;

    trig_state_t state;

    // Next record entry, zero when the trigger fires
    logic [AW-1:0] wr_ptr;

    // Rearm threshold, clamped at code zero
    scope_cfg_pkg::sample_t low_thr;

    logic below_low;
    logic at_level;
    logic last_entry;

    assign low_thr = (cfg.level > cfg.hyst) ? (cfg.level - cfg.hyst) : '0;

    assign below_low  = dec_sample <= low_thr;
    assign at_level   = dec_sample >= cfg.level;
    assign last_entry = wr_ptr == AW'(CAPTURE_DEPTH - 1);

    //////////////////////////////////////////////////////////////////////
    // Capture write, same clock as the strobe
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cap_wr.en = 1'b0;
        // Trigger sample goes to entry 0, the rest follow in order
        if (dec_valid) begin
            if (state == WAIT_HIGH && at_level) begin
                cap_wr.en = 1'b1;
            end else if (state == CAPTURE) begin
                cap_wr.en = 1'b1;
            end
        end
        cap_wr.addr = scope_cfg_pkg::cap_addr_t'(wr_ptr);
        cap_wr.data = dec_sample;
    end

    //////////////////////////////////////////////////////////////////////
    // Trigger FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            wr_ptr <= '0;
        end else if (arm) begin
            // Rearm wins over anything in flight
            state  <= WAIT_LOW;
            wr_ptr <= '0;
        end else begin
            if (cap_wr.en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (state)
                WAIT_LOW: begin
                    if (dec_valid && below_low) begin
                        state <= WAIT_HIGH;
                    end
                end
                WAIT_HIGH: begin
                    if (dec_valid && at_level) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (dec_valid && last_entry) begin
                        state <= DONE;
                    end
                end
                // IDLE and DONE hold until the host arms
                default: state <= state;
            endcase
        end
    end

    // Status flags
    assign armed = (state == WAIT_LOW) || (state == WAIT_HIGH) || (state == CAPTURE);
    assign done  = state == DONE;

endmodule

// ==== source/sample_decimator.sv ====
`timescale 1ns/1ps

module sample_decimator (
    input  logic                   clk,
    input  logic                   rst,
    input  scope_cfg_pkg::sample_t sample_in,
    input  logic                   sample_valid,
    input  scope_cfg_pkg::decim_t  decim,
    output scope_cfg_pkg::sample_t dec_sample,
    output logic                   dec_valid
);

    // Valid samples seen so far in the current group
    scope_cfg_pkg::decim_t grp_cnt;

    // Last sample of a group, only this one goes on
    logic grp_end;

    // Greater-or-equal so a lowered decim closes the group at once
    assign grp_end = sample_valid && (grp_cnt >= decim);

    //////////////////////////////////////////////////////////////////////
    // Group counter and strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            grp_cnt   <= '0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= grp_end;
            if (grp_end) begin
                grp_cnt <= '0;
            end else if (sample_valid) begin
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

    // Forwarded sample, held until the next group closes
    always_ff @(posedge clk) begin
        if (grp_end) begin
            dec_sample <= sample_in;
        end
    end

endmodule

// ==== source/scope_bus_pkg.sv ====
package scope_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic types
    //////////////////////////////////////////////////////////////////////

    localparam int WB_ADR_W = 10;
    localparam int WB_DAT_W = 16;

    // Word address and data
    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    // Master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam wb_adr_t REG_CTRL   = 10'h000;  // W, bit 0 arms a capture
    localparam wb_adr_t REG_STATUS = 10'h001;  // R, bit 0 armed, bit 1 done
    localparam wb_adr_t REG_LEVEL  = 10'h002;
    localparam wb_adr_t REG_HYST   = 10'h003;
    localparam wb_adr_t REG_DECIM  = 10'h004;

    // Capture record window starts here
    localparam wb_adr_t BUF_BASE   = 10'h200;

endpackage

// ==== source/scope_capture_top.sv ====
`timescale 1ns/1ps

module scope_capture_top #(
    parameter int CAPTURE_DEPTH = scope_cfg_pkg::DEFAULT_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  scope_cfg_pkg::sample_t sample_in,
    input  logic                   sample_valid,
    input  scope_bus_pkg::wb_req_t wb_req,
    output scope_bus_pkg::wb_rsp_t wb_rsp
);

    localparam int AW = $clog2(CAPTURE_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////////////////////////

    scope_cfg_pkg::trig_cfg_t cfg;
    scope_cfg_pkg::sample_t   dec_sample;
    scope_cfg_pkg::sample_t   rd_data;
    scope_cfg_pkg::cap_wr_t   cap_wr;

    logic          dec_valid;
    logic          arm;
    logic          armed;
    logic          done;
    logic [AW-1:0] rd_addr;

    //////////////////////////////////////////////////////////////////////
    // Sample path
    //////////////////////////////////////////////////////////////////////

    // Thins the ADC stream
    sample_decimator decim_i (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .decim        (cfg.decim),
        .dec_sample   (dec_sample),
        .dec_valid    (dec_valid)
    );

    // Trigger and record sequencing
    edge_trigger #(
        .CAPTURE_DEPTH (CAPTURE_DEPTH)
    ) trig_i (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .arm        (arm),
        .dec_sample (dec_sample),
        .dec_valid  (dec_valid),
        .cap_wr     (cap_wr),
        .armed      (armed),
        .done       (done)
    );

    capture_ram #(
        .CAPTURE_DEPTH (CAPTURE_DEPTH)
    ) ram_i (
        .clk     (clk),
        .cap_wr  (cap_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////////////////////////

    scope_wb_regs #(
        .CAPTURE_DEPTH (CAPTURE_DEPTH)
    ) regs_i (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .cfg     (cfg),
        .arm     (arm),
        .armed   (armed),
        .done    (done),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== source/scope_cfg_pkg.sv ====
package scope_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sample path
    //////////////////////////////////////////////////////////////////////

    // ADC code width
    localparam int SAMPLE_W = 12;

    // One raw ADC code, absolute scale
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Decimation count minus one, 0 keeps every sample
    typedef logic [11:0] decim_t;

    //////////////////////////////////////////////////////////////////////
    // Trigger and capture
    //////////////////////////////////////////////////////////////////////

    // Default record length in samples
    localparam int DEFAULT_DEPTH = 256;

    // Capture write address, wide enough for any supported depth
    localparam int CAP_ADDR_W = 16;

    typedef logic [CAP_ADDR_W-1:0] cap_addr_t;

    // Trigger configuration as set by the host, 36 bits
    typedef struct packed {
        sample_t level;
        sample_t hyst;
        decim_t  decim;
    } trig_cfg_t;

    // One capture write, upper address bits stay zero beyond the depth
    typedef struct packed {
        logic      en;
        cap_addr_t addr;
        sample_t   data;
    } cap_wr_t;

endpackage

// ==== source/scope_wb_regs.sv ====
`timescale 1ns/1ps

module scope_wb_regs #(
    parameter int CAPTURE_DEPTH = scope_cfg_pkg::DEFAULT_DEPTH
) (
    input  logic                             clk,
    input  logic                             rst,
    input  scope_bus_pkg::wb_req_t           wb_req,
    output scope_bus_pkg::wb_rsp_t           wb_rsp,
    output scope_cfg_pkg::trig_cfg_t         cfg,
    output logic                             arm,
    input  logic                             armed,
    input  logic                             done,
    output logic [$clog2(CAPTURE_DEPTH)-1:0] rd_addr,
    input  scope_cfg_pkg::sample_t           rd_data
);

    localparam int AW = $clog2(CAPTURE_DEPTH);
    localparam int SW = $bits(scope_cfg_pkg::sample_t);
    localparam int DW = $bits(scope_cfg_pkg::decim_t);

    logic                     ack_q;
    logic                     buf_sel_q;
    scope_bus_pkg::wb_dat_t   reg_dat_q;
    scope_bus_pkg::wb_dat_t   reg_dat;
    scope_bus_pkg::wb_dat_t   buf_dat;
    scope_cfg_pkg::trig_cfg_t cfg_q;

    logic req;
    logic take;
    logic in_buf;

    //////////////////////////////////////////////////////////////////////
    // Bus handshake
    //////////////////////////////////////////////////////////////////////

    assign req = wb_req.cyc && wb_req.stb;

    // New transfer, never in the ack cycle itself
    assign take = req && !ack_q;

    // Address falls inside the record window
    assign in_buf = (int'(wb_req.adr) >= int'(scope_bus_pkg::BUF_BASE)) &&
                    (int'(wb_req.adr) < int'(scope_bus_pkg::BUF_BASE) + CAPTURE_DEPTH);

    // Window base is depth aligned, low bits are the entry index
    assign rd_addr = wb_req.adr[AW-1:0];

    //////////////////////////////////////////////////////////////////////
    // Register read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (wb_req.adr)
            scope_bus_pkg::REG_STATUS: reg_dat = scope_bus_pkg::wb_dat_t'({done, armed});
            scope_bus_pkg::REG_LEVEL:  reg_dat = scope_bus_pkg::wb_dat_t'(cfg_q.level);
            scope_bus_pkg::REG_HYST:   reg_dat = scope_bus_pkg::wb_dat_t'(cfg_q.hyst);
            scope_bus_pkg::REG_DECIM:  reg_dat = scope_bus_pkg::wb_dat_t'(cfg_q.decim);
            // CTRL is write only, unmapped reads as zero
            default:                   reg_dat = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control and configuration
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            arm       <= 1'b0;
            buf_sel_q <= 1'b0;
            cfg_q     <= '0;
        end else begin
            ack_q <= take;
            // One clock arm pulse
            arm <= take && wb_req.we && (wb_req.adr == scope_bus_pkg::REG_CTRL) &&
                   wb_req.dat[0];
            if (take) begin
                buf_sel_q <= in_buf && !wb_req.we;
            end
            if (take && wb_req.we) begin
                case (wb_req.adr)
                    scope_bus_pkg::REG_LEVEL: cfg_q.level <= wb_req.dat[SW-1:0];
                    scope_bus_pkg::REG_HYST:  cfg_q.hyst  <= wb_req.dat[SW-1:0];
                    scope_bus_pkg::REG_DECIM: cfg_q.decim <= wb_req.dat[DW-1:0];
                    // Read-only and unmapped writes are dropped
                    default: cfg_q <= cfg_q;
                endcase
            end
        end
    end

    // Register read data, captured with the request
    always_ff @(posedge clk) begin
        if (take) begin
            reg_dat_q <= reg_dat;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    // RAM word lands in the ack cycle
    assign buf_dat = scope_bus_pkg::wb_dat_t'(rd_data);

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = buf_sel_q ? buf_dat : reg_dat_q;

    assign cfg = cfg_q;

endmodule
